// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    // ------------------------------
    // Sequencer states and classes
    // ------------------------------
    typedef enum logic [3:0] {
        ST_FETCH       = 4'd0,
        ST_DECODE      = 4'd1,
        ST_MEMADDR     = 4'd2,
        ST_MEMREAD     = 4'd3,
        ST_MEMWB       = 4'd4,
        ST_MEMWRITE    = 4'd5,
        ST_EXECUTER    = 4'd6,
        ST_ALUWB       = 4'd7,
        ST_EXECUTEI    = 4'd8,
        ST_JAL         = 4'd9,
        ST_BRANCH      = 4'd10,
        ST_LOADI       = 4'd11,
        ST_TRAP        = 4'd12,
        ST_CSR_EXECUTE = 4'd14, // 13 stays free.
        ST_CSR_WB      = 4'd15
    } ctrl_state_e;

    typedef enum logic [3:0] {
        CL_LOAD      = 4'd0,
        CL_ALU_IMM   = 4'd1,
        CL_JALR      = 4'd2,
        CL_ALU_IMM_W = 4'd3,
        CL_STORE     = 4'd4,
        CL_ALU_REG   = 4'd5,
        CL_ALU_REG_W = 4'd6,
        CL_BRANCH    = 4'd7,
        CL_JUMP      = 4'd8,
        CL_AUIPC     = 4'd9,
        CL_LUI       = 4'd10,
        CL_SYSTEM    = 4'd12,
        CL_ILLEGAL   = 4'd13
    } instr_class_e;

    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_ALU_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_ALU_IMM_W = 7'b0011011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_ALU_REG   = 7'b0110011;
    localparam logic [6:0] OPC_ALU_REG_W = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // Two views of one instruction word.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm; // CSR address or ecall/ebreak.
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_view;
        i_fields_t i_view;
    } instr_word_u;

    // ------------------------------
    // Datapath selects
    // ------------------------------
    typedef enum logic [2:0] {
        ALUOP_ADD    = 3'd0,
        ALUOP_BRANCH = 3'd1,
        ALUOP_ALU    = 3'd2,
        ALUOP_ALU_W  = 3'd3,
        ALUOP_CSR    = 3'd4
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_ALU_OUT    = 3'd0,
        RES_MEM_DATA   = 3'd1,
        RES_ALU_RESULT = 3'd2,
        RES_IMM_EXT    = 3'd3,
        RES_CSR_DATA   = 3'd4,
        RES_OLD_PC     = 3'd6
    } result_src_e;

    // Source 1 and source 2 share the width but not the meaning.
    typedef logic [1:0] alu_src_e;
    localparam alu_src_e SRC1_PC     = 2'd0;
    localparam alu_src_e SRC1_OLD_PC = 2'd1;
    localparam alu_src_e SRC1_REG    = 2'd2;
    localparam alu_src_e SRC1_IMM    = 2'd3;
    localparam alu_src_e SRC2_REG    = 2'd0;
    localparam alu_src_e SRC2_IMM    = 2'd1;
    localparam alu_src_e SRC2_FOUR   = 2'd2;
    localparam alu_src_e SRC2_CSR    = 2'd3;

    typedef enum logic [1:0] {
        CSR_MEPC   = 2'd0,
        CSR_MCAUSE = 2'd1,
        CSR_MTVEC  = 2'd2
    } csr_sel_e;

    typedef enum logic [1:0] {
        CSRC_READ_DATA = 2'd0,
        CSRC_WB_DATA   = 2'd1,
        CSRC_JUMP_ADDR = 2'd2
    } csr_src_e;

    localparam logic [3:0] MCAUSE_FETCH_MA = 4'd0;
    localparam logic [3:0] MCAUSE_ILLEGAL  = 4'd2;
    localparam logic [3:0] MCAUSE_BREAK    = 4'd3;
    localparam logic [3:0] MCAUSE_LOAD_MA  = 4'd4;
    localparam logic [3:0] MCAUSE_STORE_MA = 4'd6;
    localparam logic [3:0] MCAUSE_ECALL    = 4'd11;

    // ------------------------------
    // Bundles
    // ------------------------------
    typedef struct packed {
        logic stall_instr;
        logic stall_data;
        logic instr_addr_ma;
        logic load_addr_ma;
        logic store_addr_ma;
        logic illegal_load;
        logic illegal_alu;
    } status_t;

    typedef struct packed {
        alu_op_e     alu_op;
        result_src_e result_src;
        alu_src_e    alu_src_1;
        alu_src_e    alu_src_2;
        logic        pc_src;
        logic        reg_write_en;
        logic        pc_update;
        logic        mem_write_en;
        logic        instr_write_en;
        logic        branch;
        logic        mem_reg_we;
        logic        fetch_state;
        logic        reg_mem_addr_we;
    } dp_ctrl_t;

    typedef struct packed {
        logic start_i_cache;
        logic start_d_cache;
    } mem_start_t;

    typedef struct packed {
        logic       csr_we;
        logic       csr_reg_we;
        logic       csr_write_src; // Selects the mcause value.
        csr_sel_e   csr_write_addr;
        csr_sel_e   csr_read_addr;
        csr_src_e   csr_src_control;
        logic [3:0] mcause;
    } csr_ctrl_t;

    typedef struct packed {
        instr_class_e cls;
        logic         sys_csr; // SYSTEM with funct3 nonzero.
        logic         f3_imm;
        logic         m_ext;
        logic         brk;
    } decode_t;

endpackage

// File: logic/instr_decoder.sv
module instr_decoder
    import ctrl_pkg::*;
(
    input  instr_word_u i_instr,
    output decode_t     o_dec
);

    instr_class_e cls;

    always_comb begin
        case (i_instr.r_view.opcode)
            OPC_LOAD:      cls = CL_LOAD;
            OPC_ALU_IMM:   cls = CL_ALU_IMM;
            OPC_JALR:      cls = CL_JALR;
            OPC_ALU_IMM_W: cls = CL_ALU_IMM_W;
            OPC_STORE:     cls = CL_STORE;
            OPC_ALU_REG:   cls = CL_ALU_REG;
            OPC_ALU_REG_W: cls = CL_ALU_REG_W;
            OPC_BRANCH:    cls = CL_BRANCH;
            OPC_JAL:       cls = CL_JUMP;
            OPC_AUIPC:     cls = CL_AUIPC;
            OPC_LUI:       cls = CL_LUI;
            OPC_SYSTEM:    cls = CL_SYSTEM;
            default:       cls = CL_ILLEGAL; // FENCE lands here too.
        endcase
    end

    // ------------------------------
    // Flags
    // ------------------------------
    always_comb begin
        o_dec.cls     = cls;
        o_dec.sys_csr = (cls == CL_SYSTEM) && (i_instr.i_view.funct3 != 3'd0);
        o_dec.f3_imm  = i_instr.i_view.funct3[2]; // CSR immediate form.
        // Bit 25 marks a MUL/DIV op, which is not supported.
        o_dec.m_ext   = i_instr.r_view.funct7[0]
                        && ((cls == CL_ALU_REG) || (cls == CL_ALU_REG_W));
        o_dec.brk     = i_instr.i_view.imm[0]; // Ebreak, else ecall.
    end

    always_comb begin
        if (!$isunknown(i_instr)) begin
            assert (!$isunknown(o_dec.cls))
            else $error("instr_decoder: unknown class for a known instruction");
        end
    end

endmodule

// File: logic/trap_detect.sv
module trap_detect
    import ctrl_pkg::*;
(
    input  ctrl_state_e i_state,
    input  decode_t     i_dec,
    input  status_t     i_status,
    output logic        o_trap,
    output logic [3:0]  o_mcause
);

    // One trap source set per state.
    always_comb begin
        o_trap   = 1'b0;
        o_mcause = 4'd0;

        case (i_state)
            ST_FETCH: begin
                if (i_status.instr_addr_ma) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_FETCH_MA;
                end
            end

            ST_DECODE: begin
                if (i_dec.cls == CL_ILLEGAL) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_ILLEGAL;
                end else if ((i_dec.cls == CL_SYSTEM) && !i_dec.sys_csr) begin
                    o_trap   = 1'b1;
                    o_mcause = i_dec.brk ? MCAUSE_BREAK : MCAUSE_ECALL;
                end
            end

            ST_MEMREAD: begin
                if (i_status.illegal_load) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_ILLEGAL; // Wins over misalignment.
                end else if (i_status.load_addr_ma) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_LOAD_MA;
                end
            end

            ST_MEMWRITE: begin
                if (i_status.store_addr_ma) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_STORE_MA;
                end
            end

            ST_ALUWB: begin
                if (i_status.illegal_alu || i_dec.m_ext) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_ILLEGAL;
                end
            end

            ST_CSR_EXECUTE: begin
                if (i_status.illegal_alu) begin
                    o_trap   = 1'b1;
                    o_mcause = MCAUSE_ILLEGAL;
                end
            end

            default: ;
        endcase
    end

endmodule

// File: logic/state_seq.sv
module state_seq
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        arstn,
    input  decode_t     i_dec,
    input  status_t     i_status,
    input  logic        i_trap,
    output ctrl_state_e o_state
);

    ctrl_state_e state;
    ctrl_state_e next_state;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = state;

        if (i_trap) begin
            next_state = ST_TRAP; // Beats any stall.
        end else begin
            case (state)
                ST_FETCH:    if (!i_status.stall_instr) next_state = ST_DECODE;

                ST_DECODE: begin
                    case (i_dec.cls)
                        CL_LOAD, CL_STORE, CL_JALR:       next_state = ST_MEMADDR;
                        CL_ALU_IMM, CL_ALU_IMM_W:         next_state = ST_EXECUTEI;
                        CL_ALU_REG, CL_ALU_REG_W:         next_state = ST_EXECUTER;
                        CL_BRANCH:                        next_state = ST_BRANCH;
                        CL_JUMP:                          next_state = ST_JAL;
                        CL_AUIPC:                         next_state = ST_ALUWB;
                        CL_LUI:                           next_state = ST_LOADI;
                        CL_SYSTEM:                        next_state = ST_CSR_EXECUTE;
                        default:                          next_state = ST_FETCH;
                    endcase
                end

                ST_MEMADDR: begin
                    case (i_dec.cls)
                        CL_LOAD:  next_state = ST_MEMREAD;
                        CL_STORE: next_state = ST_MEMWRITE;
                        CL_JALR:  next_state = ST_JAL; // Target is in the ALU register.
                        default:  next_state = ST_FETCH;
                    endcase
                end

                ST_MEMREAD:  if (!i_status.stall_data) next_state = ST_MEMWB;
                ST_MEMWRITE: if (!i_status.stall_data) next_state = ST_FETCH;

                ST_EXECUTER,
                ST_EXECUTEI,
                ST_JAL:         next_state = ST_ALUWB;

                ST_CSR_EXECUTE: next_state = ST_CSR_WB;

                default:        next_state = ST_FETCH; // Write-back, BRANCH, LOADI, TRAP.
            endcase
        end
    end

    assign o_state = state;

    a_no_free_code: assert property (@(posedge clk) disable iff (!arstn)
        state != ctrl_state_e'(4'd13));

    // Trap entry lasts one cycle.
    a_trap_to_fetch: assert property (@(posedge clk) disable iff (!arstn)
        state == ST_TRAP |=> state == ST_FETCH);

endmodule

// File: logic/ctrl_out_decode.sv
module ctrl_out_decode
    import ctrl_pkg::*;
(
    input  ctrl_state_e i_state,
    input  decode_t     i_dec,
    input  status_t     i_status,
    input  logic        i_trap,
    input  logic [3:0]  i_mcause,
    input  instr_word_u i_instr,
    output dp_ctrl_t    o_dp,
    output mem_start_t  o_mem,
    output csr_ctrl_t   o_csr
);

    csr_sel_e csr_field;

    // CSR select sits in instruction bits 22:21.
    assign csr_field = csr_sel_e'(i_instr.i_view.imm[2:1]);

    always_comb begin
        o_dp  = '0;
        o_mem = '0;
        o_csr = '0;
        o_csr.csr_write_addr = csr_field;
        o_csr.csr_read_addr  = csr_field;

        case (i_state)
            // ------------------------------
            // Fetch and decode
            // ------------------------------
            ST_FETCH: begin
                o_mem.start_i_cache   = 1'b1;
                o_dp.fetch_state      = 1'b1;
                o_dp.instr_write_en   = !i_status.stall_instr;
                o_dp.pc_update        = !i_status.stall_instr;
                o_dp.alu_src_1        = SRC1_PC;
                o_dp.alu_src_2        = SRC2_FOUR; // PC + 4.
                o_dp.result_src       = RES_ALU_RESULT;
            end

            ST_DECODE: begin
                o_dp.alu_src_1 = SRC1_OLD_PC; // Branch and jump target.
                o_dp.alu_src_2 = SRC2_IMM;
            end

            // ------------------------------
            // Memory access
            // ------------------------------
            ST_MEMADDR: begin
                o_dp.alu_src_1       = SRC1_REG;
                o_dp.alu_src_2       = SRC2_IMM;
                o_dp.result_src      = RES_ALU_RESULT;
                o_dp.reg_mem_addr_we = 1'b1;
            end

            ST_MEMREAD: begin
                o_mem.start_d_cache = 1'b1;
                o_dp.mem_reg_we     = !i_status.stall_data;
                o_dp.alu_src_1      = SRC1_REG;
                o_dp.alu_src_2      = SRC2_IMM;
            end

            ST_MEMWB: begin
                o_dp.result_src   = RES_MEM_DATA;
                o_dp.reg_write_en = 1'b1;
            end

            ST_MEMWRITE: begin
                o_mem.start_d_cache = 1'b1;
                o_dp.mem_write_en   = !i_status.stall_data;
                o_dp.mem_reg_we     = !i_status.stall_data;
                o_dp.alu_src_1      = SRC1_REG;
                o_dp.alu_src_2      = SRC2_IMM;
            end

            // ------------------------------
            // Execute and write-back
            // ------------------------------
            ST_EXECUTER: begin
                o_dp.alu_src_1 = SRC1_REG;
                o_dp.alu_src_2 = SRC2_REG;
                o_dp.alu_op    = (i_dec.cls == CL_ALU_REG_W) ? ALUOP_ALU_W : ALUOP_ALU;
            end

            ST_EXECUTEI: begin
                o_dp.alu_src_1 = SRC1_REG;
                o_dp.alu_src_2 = SRC2_IMM;
                o_dp.alu_op    = (i_dec.cls == CL_ALU_IMM_W) ? ALUOP_ALU_W : ALUOP_ALU;
            end

            ST_ALUWB: o_dp.reg_write_en = 1'b1;

            ST_JAL: begin
                o_dp.alu_src_1 = SRC1_OLD_PC; // Link address.
                o_dp.alu_src_2 = SRC2_FOUR;
                o_dp.pc_update = 1'b1;
                o_csr.csr_read_addr   = CSR_MEPC;
                o_csr.csr_src_control = CSRC_READ_DATA;
            end

            ST_BRANCH: begin
                o_dp.alu_src_1 = SRC1_REG;
                o_dp.alu_src_2 = SRC2_REG;
                o_dp.alu_op    = ALUOP_BRANCH;
                o_dp.branch    = 1'b1;
            end

            ST_LOADI: begin
                o_dp.result_src   = RES_IMM_EXT;
                o_dp.reg_write_en = 1'b1;
            end

            ST_TRAP: begin
                o_csr.csr_read_addr   = CSR_MTVEC;
                o_csr.csr_src_control = CSRC_JUMP_ADDR;
                o_csr.csr_write_addr  = CSR_MEPC; // Save the faulting PC.
                o_csr.csr_we          = 1'b1;
                o_dp.pc_src           = 1'b1;
                o_dp.pc_update        = 1'b1;
                o_dp.result_src       = RES_OLD_PC;
            end

            // ------------------------------
            // CSR access
            // ------------------------------
            ST_CSR_EXECUTE: begin
                o_dp.alu_src_1   = i_dec.f3_imm ? SRC1_IMM : SRC1_REG;
                o_dp.alu_src_2   = SRC2_CSR;
                o_dp.alu_op      = ALUOP_CSR;
                o_dp.result_src  = RES_ALU_RESULT;
                o_csr.csr_we     = 1'b1;
                o_csr.csr_reg_we = 1'b1; // Old CSR value to a register.
            end

            ST_CSR_WB: begin
                o_dp.reg_write_en     = 1'b1;
                o_dp.result_src       = RES_CSR_DATA;
                o_csr.csr_src_control = CSRC_WB_DATA;
            end

            default: ;
        endcase

        // A trap records its cause and cancels the cache request.
        if (i_trap) begin
            o_csr.csr_we         = 1'b1;
            o_csr.csr_write_src  = 1'b1;
            o_csr.csr_write_addr = CSR_MCAUSE;
            o_csr.mcause         = i_mcause;
            o_mem                = '0;
        end

        assert (!o_csr.csr_write_src || o_csr.csr_we)
        else $error("ctrl_out_decode: mcause source without a CSR write");
        assert (!(o_dp.reg_write_en && o_dp.mem_write_en))
        else $error("ctrl_out_decode: register and memory write together");
    end

endmodule

// File: logic/main_ctrl.sv
module main_ctrl
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        arstn,
    input  instr_word_u i_instr,
    input  status_t     i_status,
    output dp_ctrl_t    o_dp,
    output mem_start_t  o_mem,
    output csr_ctrl_t   o_csr
);

    decode_t     dec;
    ctrl_state_e state;
    logic        trap;
    logic [3:0]  mcause;

    instr_decoder u_decoder (
        .i_instr (i_instr),
        .o_dec   (dec)
    );

    // Single place where trap conditions are tested.
    trap_detect u_trap (
        .i_state  (state),
        .i_dec    (dec),
        .i_status (i_status),
        .o_trap   (trap),
        .o_mcause (mcause)
    );

    state_seq u_seq (
        .clk      (clk),
        .arstn    (arstn),
        .i_dec    (dec),
        .i_status (i_status),
        .i_trap   (trap),
        .o_state  (state)
    );

    ctrl_out_decode u_out (
        .i_state  (state),
        .i_dec    (dec),
        .i_status (i_status),
        .i_trap   (trap),
        .i_mcause (mcause),
        .i_instr  (i_instr),
        .o_dp     (o_dp),
        .o_mem    (o_mem),
        .o_csr    (o_csr)
    );

endmodule

// File: dv/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// One cycle of expected DUT outputs.
typedef struct packed {
    dp_ctrl_t   dp;
    mem_start_t mem;
    csr_ctrl_t  csr;
} expect_t;

ctrl_state_e mirror_state; // Follows the DUT state.

function automatic logic opcode_known(input logic [6:0] opc);
    return opc inside {OPC_LOAD, OPC_ALU_IMM, OPC_JALR, OPC_ALU_IMM_W, OPC_STORE,
                       OPC_ALU_REG, OPC_ALU_REG_W, OPC_BRANCH, OPC_JAL, OPC_AUIPC,
                       OPC_LUI, OPC_SYSTEM};
endfunction

// Bit 4 flags a trap, bits 3:0 hold its cause.
function automatic logic [4:0] trap_of_state(input ctrl_state_e st, input instr_word_u ins,
                                             input status_t s);
    logic [6:0] opc;
    logic       mul_div;
    logic [4:0] res;
    opc     = ins.r_view.opcode;
    mul_div = ins.r_view.funct7[0] && (opc == OPC_ALU_REG || opc == OPC_ALU_REG_W);
    res     = 5'd0;
    case (st)
        ST_FETCH:       if (s.instr_addr_ma) res = {1'b1, MCAUSE_FETCH_MA};
        ST_DECODE: begin
            if (!opcode_known(opc)) begin
                res = {1'b1, MCAUSE_ILLEGAL};
            end else if (opc == OPC_SYSTEM && ins.i_view.funct3 == 3'd0) begin
                res = {1'b1, ins.i_view.imm[0] ? MCAUSE_BREAK : MCAUSE_ECALL};
            end
        end
        ST_MEMREAD: begin
            if (s.illegal_load) res = {1'b1, MCAUSE_ILLEGAL};
            else if (s.load_addr_ma) res = {1'b1, MCAUSE_LOAD_MA};
        end
        ST_MEMWRITE:    if (s.store_addr_ma) res = {1'b1, MCAUSE_STORE_MA};
        ST_ALUWB:       if (s.illegal_alu || mul_div) res = {1'b1, MCAUSE_ILLEGAL};
        ST_CSR_EXECUTE: if (s.illegal_alu) res = {1'b1, MCAUSE_ILLEGAL};
        default: ;
    endcase
    return res;
endfunction

function automatic ctrl_state_e next_mirror_state(input ctrl_state_e st,
                                                  input instr_word_u ins, input status_t s);
    logic [6:0]  opc;
    ctrl_state_e nxt;
    opc = ins.r_view.opcode;
    nxt = ST_FETCH;
    if (trap_of_state(st, ins, s) != 5'd0) begin
        nxt = ST_TRAP;
    end else begin
        case (st)
            ST_FETCH:    nxt = s.stall_instr ? ST_FETCH : ST_DECODE;
            ST_DECODE: begin
                case (opc)
                    OPC_LOAD, OPC_STORE, OPC_JALR:  nxt = ST_MEMADDR;
                    OPC_ALU_IMM, OPC_ALU_IMM_W:     nxt = ST_EXECUTEI;
                    OPC_ALU_REG, OPC_ALU_REG_W:     nxt = ST_EXECUTER;
                    OPC_BRANCH:                     nxt = ST_BRANCH;
                    OPC_JAL:                        nxt = ST_JAL;
                    OPC_AUIPC:                      nxt = ST_ALUWB;
                    OPC_LUI:                        nxt = ST_LOADI;
                    OPC_SYSTEM:                     nxt = ST_CSR_EXECUTE;
                    default:                        nxt = ST_FETCH;
                endcase
            end
            ST_MEMADDR: begin
                if (opc == OPC_LOAD) nxt = ST_MEMREAD;
                else if (opc == OPC_STORE) nxt = ST_MEMWRITE;
                else if (opc == OPC_JALR) nxt = ST_JAL;
            end
            ST_MEMREAD:  nxt = s.stall_data ? ST_MEMREAD : ST_MEMWB;
            ST_MEMWRITE: nxt = s.stall_data ? ST_MEMWRITE : ST_FETCH;
            ST_EXECUTER, ST_EXECUTEI, ST_JAL: nxt = ST_ALUWB;
            ST_CSR_EXECUTE: nxt = ST_CSR_WB;
            default: nxt = ST_FETCH;
        endcase
    end
    return nxt;
endfunction

function automatic expect_t expected_outputs(input ctrl_state_e st, input instr_word_u ins,
                                             input status_t s);
    expect_t    e;
    logic [4:0] t;
    logic [6:0] opc;
    opc = ins.r_view.opcode;
    t   = trap_of_state(st, ins, s);
    e   = '0;
    e.csr.csr_write_addr = csr_sel_e'(ins.i_view.imm[2:1]);
    e.csr.csr_read_addr  = csr_sel_e'(ins.i_view.imm[2:1]);
    case (st)
        ST_FETCH: begin
            e.mem.start_i_cache  = 1'b1;
            e.dp.fetch_state     = 1'b1;
            e.dp.instr_write_en  = !s.stall_instr;
            e.dp.pc_update       = !s.stall_instr;
            e.dp.alu_src_1       = SRC1_PC;
            e.dp.alu_src_2       = SRC2_FOUR;
            e.dp.result_src      = RES_ALU_RESULT;
        end
        ST_DECODE: begin
            e.dp.alu_src_1 = SRC1_OLD_PC;
            e.dp.alu_src_2 = SRC2_IMM;
        end
        ST_MEMADDR: begin
            e.dp.alu_src_1       = SRC1_REG;
            e.dp.alu_src_2       = SRC2_IMM;
            e.dp.result_src      = RES_ALU_RESULT;
            e.dp.reg_mem_addr_we = 1'b1;
        end
        ST_MEMREAD, ST_MEMWRITE: begin
            e.mem.start_d_cache = 1'b1;
            e.dp.mem_reg_we     = !s.stall_data;
            e.dp.mem_write_en   = (st == ST_MEMWRITE) && !s.stall_data;
            e.dp.alu_src_1      = SRC1_REG;
            e.dp.alu_src_2      = SRC2_IMM;
        end
        ST_MEMWB: begin
            e.dp.result_src   = RES_MEM_DATA;
            e.dp.reg_write_en = 1'b1;
        end
        ST_EXECUTER, ST_EXECUTEI: begin
            e.dp.alu_src_1 = SRC1_REG;
            e.dp.alu_src_2 = (st == ST_EXECUTER) ? SRC2_REG : SRC2_IMM;
            // W forms use their own ALU op.
            if (opc == OPC_ALU_REG_W || opc == OPC_ALU_IMM_W) e.dp.alu_op = ALUOP_ALU_W;
            else e.dp.alu_op = ALUOP_ALU;
        end
        ST_ALUWB: e.dp.reg_write_en = 1'b1;
        ST_JAL: begin
            e.dp.alu_src_1      = SRC1_OLD_PC;
            e.dp.alu_src_2      = SRC2_FOUR;
            e.dp.pc_update      = 1'b1;
            e.csr.csr_read_addr = CSR_MEPC;
        end
        ST_BRANCH: begin
            e.dp.alu_src_1 = SRC1_REG;
            e.dp.alu_src_2 = SRC2_REG;
            e.dp.alu_op    = ALUOP_BRANCH;
            e.dp.branch    = 1'b1;
        end
        ST_LOADI: begin
            e.dp.result_src   = RES_IMM_EXT;
            e.dp.reg_write_en = 1'b1;
        end
        ST_TRAP: begin
            e.csr.csr_read_addr   = CSR_MTVEC;
            e.csr.csr_src_control = CSRC_JUMP_ADDR;
            e.csr.csr_write_addr  = CSR_MEPC;
            e.csr.csr_we          = 1'b1;
            e.dp.pc_src           = 1'b1;
            e.dp.pc_update        = 1'b1;
            e.dp.result_src       = RES_OLD_PC;
        end
        ST_CSR_EXECUTE: begin
            e.dp.alu_src_1   = ins.i_view.funct3[2] ? SRC1_IMM : SRC1_REG;
            e.dp.alu_src_2   = SRC2_CSR;
            e.dp.alu_op      = ALUOP_CSR;
            e.dp.result_src  = RES_ALU_RESULT;
            e.csr.csr_we     = 1'b1;
            e.csr.csr_reg_we = 1'b1;
        end
        ST_CSR_WB: begin
            e.dp.reg_write_en     = 1'b1;
            e.dp.result_src       = RES_CSR_DATA;
            e.csr.csr_src_control = CSRC_WB_DATA;
        end
        default: ;
    endcase
    if (t[4]) begin
        e.csr.csr_we         = 1'b1; // Cause goes to MCAUSE.
        e.csr.csr_write_src  = 1'b1;
        e.csr.csr_write_addr = CSR_MCAUSE;
        e.csr.mcause         = t[3:0];
        e.mem                = '0;
    end
    return e;
endfunction

`endif

// File: dv/tb_main_ctrl.sv
module tb_main_ctrl
    import ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CYCLES   = 3000;
    localparam int CLK_PERIOD = 10;
    localparam logic [15:0] CAUSES_NEEDED = (16'd1 << MCAUSE_FETCH_MA) |
        (16'd1 << MCAUSE_ILLEGAL) | (16'd1 << MCAUSE_BREAK) | (16'd1 << MCAUSE_LOAD_MA) |
        (16'd1 << MCAUSE_STORE_MA) | (16'd1 << MCAUSE_ECALL);
    localparam logic [15:0] STATES_NEEDED = 16'hDFFF; // All but code 13.

    logic        clk;
    logic        arstn;
    instr_word_u instr;
    status_t     status;
    dp_ctrl_t    dp;
    mem_start_t  mem;
    csr_ctrl_t   csr;
    integer      seed;
    logic [15:0] causes_seen;
    logic [15:0] states_seen;

    `include "tb_ref_model.svh"

    main_ctrl u_dut (
        .clk      (clk),
        .arstn    (arstn),
        .i_instr  (instr),
        .i_status (status),
        .o_dp     (dp),
        .o_mem    (mem),
        .o_csr    (csr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic int unsigned pct();
        return $unsigned($random(seed)) % 100;
    endfunction

    function automatic logic [6:0] pick_opcode(input int unsigned k);
        if (k < 10) return k[0] ? 7'b0001111 : 7'b1111111; // Unknown opcodes.
        case ((k - 10) % 12)
            0:       return OPC_LOAD;
            1:       return OPC_ALU_IMM;
            2:       return OPC_JALR;
            3:       return OPC_ALU_IMM_W;
            4:       return OPC_STORE;
            5:       return OPC_ALU_REG;
            6:       return OPC_ALU_REG_W;
            7:       return OPC_BRANCH;
            8:       return OPC_JAL;
            9:       return OPC_AUIPC;
            10:      return OPC_LUI;
            default: return OPC_SYSTEM;
        endcase
    endfunction

    function automatic instr_word_u random_instr();
        logic [31:0] word;
        logic [6:0]  opc;
        word      = $random(seed);
        opc       = pick_opcode(pct());
        word[6:0] = opc;
        // Push some SYSTEM words toward ecall and ebreak.
        if (opc == OPC_SYSTEM && pct() < 40) word[14:12] = 3'd0;
        return instr_word_u'(word);
    endfunction

    function automatic status_t random_status();
        status_t s;
        s.stall_instr   = pct() < 20;
        s.stall_data    = pct() < 20;
        s.instr_addr_ma = pct() < 5;
        s.load_addr_ma  = pct() < 5;
        s.store_addr_ma = pct() < 5;
        s.illegal_load  = pct() < 5;
        s.illegal_alu   = pct() < 5;
        return s;
    endfunction

    task automatic drive_inputs();
        if (mirror_state == ST_FETCH) instr = random_instr(); // Held past FETCH.
        status = random_status();
    endtask

    // ------------------------------
    // Checking
    // ------------------------------
    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        if (got !== want) begin
            $display("error: time %0t %s got %0h expected %0h", $time, name, got, want);
            $display("TB FAILED");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_value("alu_op", 8'(dp.alu_op), 8'(e.dp.alu_op));
        check_value("result_src", 8'(dp.result_src), 8'(e.dp.result_src));
        check_value("alu_src_1", 8'(dp.alu_src_1), 8'(e.dp.alu_src_1));
        check_value("alu_src_2", 8'(dp.alu_src_2), 8'(e.dp.alu_src_2));
        check_value("pc_src", 8'(dp.pc_src), 8'(e.dp.pc_src));
        check_value("reg_write_en", 8'(dp.reg_write_en), 8'(e.dp.reg_write_en));
        check_value("pc_update", 8'(dp.pc_update), 8'(e.dp.pc_update));
        check_value("mem_write_en", 8'(dp.mem_write_en), 8'(e.dp.mem_write_en));
        check_value("instr_write_en", 8'(dp.instr_write_en), 8'(e.dp.instr_write_en));
        check_value("branch", 8'(dp.branch), 8'(e.dp.branch));
        check_value("mem_reg_we", 8'(dp.mem_reg_we), 8'(e.dp.mem_reg_we));
        check_value("fetch_state", 8'(dp.fetch_state), 8'(e.dp.fetch_state));
        check_value("reg_mem_addr_we", 8'(dp.reg_mem_addr_we), 8'(e.dp.reg_mem_addr_we));
        check_value("start_i_cache", 8'(mem.start_i_cache), 8'(e.mem.start_i_cache));
        check_value("start_d_cache", 8'(mem.start_d_cache), 8'(e.mem.start_d_cache));
        check_value("csr_we", 8'(csr.csr_we), 8'(e.csr.csr_we));
        check_value("csr_reg_we", 8'(csr.csr_reg_we), 8'(e.csr.csr_reg_we));
        check_value("csr_write_src", 8'(csr.csr_write_src), 8'(e.csr.csr_write_src));
        check_value("csr_write_addr", 8'(csr.csr_write_addr), 8'(e.csr.csr_write_addr));
        check_value("csr_read_addr", 8'(csr.csr_read_addr), 8'(e.csr.csr_read_addr));
        check_value("csr_src_control", 8'(csr.csr_src_control), 8'(e.csr.csr_src_control));
        check_value("mcause", 8'(csr.mcause), 8'(e.csr.mcause));
    endtask

    // ------------------------------
    // Reset and stimulus
    // ------------------------------
    initial begin
        seed         = 66;
        clk          = 1'b0;
        arstn        = 1'b0;
        instr        = '0;
        status       = '0;
        mirror_state = ST_FETCH;
        causes_seen  = '0;
        states_seen  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
        instr = random_instr(); // First cycle runs with quiet status.
        repeat (N_CYCLES) begin
            @(negedge clk);
            drive_inputs();
        end
    end

    // Compare just before each rising edge.
    initial begin : compare_proc
        expect_t     want;
        logic [4:0]  trap_info;
        int unsigned cycle;
        @(posedge arstn);
        for (cycle = 0; cycle < N_CYCLES; cycle++) begin
            #2;
            if (cycle == 0) begin
                check_value("start_i_cache after reset", 8'(mem.start_i_cache), 8'd1);
                check_value("fetch_state after reset", 8'(dp.fetch_state), 8'd1);
                check_value("reg_write_en after reset", 8'(dp.reg_write_en), 8'd0);
                check_value("mem_write_en after reset", 8'(dp.mem_write_en), 8'd0);
                check_value("csr_we after reset", 8'(csr.csr_we), 8'd0);
            end
            want      = expected_outputs(mirror_state, instr, status);
            trap_info = trap_of_state(mirror_state, instr, status);
            check_outputs(want);
            if (trap_info[4]) causes_seen[trap_info[3:0]] = 1'b1;
            states_seen[mirror_state] = 1'b1;
            mirror_state = next_mirror_state(mirror_state, instr, status);
            @(negedge clk);
        end
        if ((causes_seen & CAUSES_NEEDED) != CAUSES_NEEDED
                || (states_seen & STATES_NEEDED) != STATES_NEEDED) begin
            $display("not every trap cause or state was reached during the run");
            $display("TB FAILED");
            $fatal(1, "incomplete stimulus");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // Twice the nominal run length.
    initial begin
        #(N_CYCLES * CLK_PERIOD * 2);
        $display("the run timed out before all cycles were checked");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: all.f
+incdir+dv
logic/ctrl_pkg.sv
logic/instr_decoder.sv
logic/trap_detect.sv
logic/state_seq.sv
logic/ctrl_out_decode.sv
logic/main_ctrl.sv
dv/tb_main_ctrl.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a $fatal gives a nonzero exit.
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_main_ctrl \
    -f all.f -o sim_main_ctrl &&
./obj_dir/sim_main_ctrl &&
echo "simulation finished" ||
{ echo "simulation failed"; exit 1; }
